// ==== include/branch_macros.svh ====
`ifndef BRANCH_MACROS_SVH
`define BRANCH_MACROS_SVH

// operand and result data width
`define BR_DATA_W 32

// program counter width
`define BR_ADDR_W 32

// rename tag width, a tag of zero means the value is already present
`define BR_TAG_W 4

// station entries, must stay a power of two so the pointers wrap on their own
`define BR_RS_DEPTH 4

// log2 of the station depth
`define BR_PTR_W 2

`endif

// ==== verilog/branchPkg.sv ====
`default_nettype none

`include "branch_macros.svh"

package branchPkg;

    // branch and jump opcodes handled by the branch reservation station
    typedef enum logic [3:0] {
        BR_NOP,
        BR_BEQ,
        BR_BNE,
        BR_BLT,
        BR_BGE,
        BR_BLTU,
        BR_BGEU,
        BR_JAL,
        BR_JALR
    } brOpE;

    // one registered result of the branch executor
    typedef struct packed {
        logic                  valid;
        logic                  taken;
        logic [`BR_ADDR_W-1:0] target;
        // link value, broadcast under dest
        logic [`BR_DATA_W-1:0] link;
        logic [`BR_TAG_W-1:0]  dest;
    } brResultT;

endpackage

`default_nettype wire

// ==== verilog/wakeupIf.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

// the two result buses that waiting entries snoop for their operands
interface wakeupIf;
    logic                  aluValid;
    logic [`BR_TAG_W-1:0]  aluTag;
    logic [`BR_DATA_W-1:0] aluData;
    logic                  lsValid;
    logic [`BR_TAG_W-1:0]  lsTag;
    logic [`BR_DATA_W-1:0] lsData;

    modport source(output aluValid, aluTag, aluData, lsValid, lsTag, lsData);

    modport snoop(input aluValid, aluTag, aluData, lsValid, lsTag, lsData);
endinterface

`default_nettype wire

// ==== verilog/rsEntry.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module rsEntry (
    input  logic                  clk,
    input  logic                  rst,
    wakeupIf.snoop                snoop,
    input  logic                  alloc,
    input  branchPkg::brOpE       allocOp,
    input  logic [`BR_DATA_W-1:0] allocA,
    input  logic [`BR_DATA_W-1:0] allocB,
    input  logic [`BR_DATA_W-1:0] allocImm,
    input  logic [`BR_TAG_W-1:0]  allocTagA,
    input  logic [`BR_TAG_W-1:0]  allocTagB,
    input  logic [`BR_TAG_W-1:0]  allocDest,
    input  logic [`BR_ADDR_W-1:0] allocPc,
    input  logic                  occupied,
    output logic                  ready,
    output logic [`BR_DATA_W-1:0] opA,
    output logic [`BR_DATA_W-1:0] opB,
    output logic [`BR_DATA_W-1:0] imm,
    output branchPkg::brOpE       op,
    output logic [`BR_ADDR_W-1:0] pc,
    output logic [`BR_TAG_W-1:0]  dest
);
    logic [`BR_TAG_W-1:0]  tagA;
    logic [`BR_TAG_W-1:0]  tagB;
    logic [`BR_DATA_W-1:0] dataA;
    logic [`BR_DATA_W-1:0] dataB;
    logic [`BR_TAG_W-1:0]  nextTagA;
    logic [`BR_TAG_W-1:0]  nextTagB;
    logic [`BR_DATA_W-1:0] nextDataA;
    logic [`BR_DATA_W-1:0] nextDataB;

    // the ALU bus wins if both buses carry the same tag, which the core never does
    always_comb begin
        nextTagA = tagA;
        nextDataA = dataA;
        if (tagA != '0 && snoop.aluValid && snoop.aluTag == tagA) begin
            nextTagA = '0;
            nextDataA = snoop.aluData;
        end else if (tagA != '0 && snoop.lsValid && snoop.lsTag == tagA) begin
            nextTagA = '0;
            nextDataA = snoop.lsData;
        end
    end

    always_comb begin
        nextTagB = tagB;
        nextDataB = dataB;
        if (tagB != '0 && snoop.aluValid && snoop.aluTag == tagB) begin
            nextTagB = '0;
            nextDataB = snoop.aluData;
        end else if (tagB != '0 && snoop.lsValid && snoop.lsTag == tagB) begin
            nextTagB = '0;
            nextDataB = snoop.lsData;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tagA <= '0;
            tagB <= '0;
        end else if (alloc) begin
            tagA <= allocTagA;
            tagB <= allocTagB;
        end else begin
            tagA <= nextTagA;
            tagB <= nextTagB;
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            dataA <= allocA;
            dataB <= allocB;
            imm <= allocImm;
            op <= allocOp;
            pc <= allocPc;
            dest <= allocDest;
        end else begin
            dataA <= nextDataA;
            dataB <= nextDataB;
        end
    end

    // bypassed view, so a broadcast this cycle already counts
    assign opA = nextDataA;
    assign opB = nextDataB;
    assign ready = occupied && nextTagA == '0 && nextTagB == '0;

endmodule

`default_nettype wire

// ==== verilog/rsQueuePointers.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module rsQueuePointers (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  logic                 pop,
    output logic [`BR_PTR_W-1:0] head,
    output logic [`BR_PTR_W-1:0] tail,
    output logic                 full
);
    logic [`BR_PTR_W:0] count;
    logic               doPush;

    // a push into a full station is dropped
    assign doPush = push && !full;
    assign full = count == (`BR_PTR_W+1)'(`BR_RS_DEPTH);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head <= '0;
            tail <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                tail <= tail + 1'b1;
            end
            if (pop) begin
                head <= head + 1'b1;
            end
            // push and pop together leave the count alone
            if (doPush && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/branchStation.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module branchStation (
    input  logic                  clk,
    input  logic                  rst,
    wakeupIf.snoop                snoop,
    input  logic                  dispatchEn,
    input  branchPkg::brOpE       dispatchOp,
    input  logic [`BR_DATA_W-1:0] dispatchA,
    input  logic [`BR_DATA_W-1:0] dispatchB,
    input  logic [`BR_DATA_W-1:0] dispatchImm,
    input  logic [`BR_TAG_W-1:0]  dispatchTagA,
    input  logic [`BR_TAG_W-1:0]  dispatchTagB,
    input  logic [`BR_TAG_W-1:0]  dispatchDest,
    input  logic [`BR_ADDR_W-1:0] dispatchPc,
    output logic                  full,
    output logic                  issueValid,
    output branchPkg::brOpE       issueOp,
    output logic [`BR_DATA_W-1:0] issueA,
    output logic [`BR_DATA_W-1:0] issueB,
    output logic [`BR_DATA_W-1:0] issueImm,
    output logic [`BR_ADDR_W-1:0] issuePc,
    output logic [`BR_TAG_W-1:0]  issueDest
);
    logic [`BR_PTR_W-1:0]   head;
    logic [`BR_PTR_W-1:0]   tail;
    logic [`BR_RS_DEPTH-1:0] allocVec;
    logic [`BR_RS_DEPTH-1:0] occupied;
    logic [`BR_RS_DEPTH-1:0] ready;
    logic                    pop;

    logic [`BR_DATA_W-1:0] entA [`BR_RS_DEPTH];
    logic [`BR_DATA_W-1:0] entB [`BR_RS_DEPTH];
    logic [`BR_DATA_W-1:0] entImm [`BR_RS_DEPTH];
    branchPkg::brOpE       entOp [`BR_RS_DEPTH];
    logic [`BR_ADDR_W-1:0] entPc [`BR_RS_DEPTH];
    logic [`BR_TAG_W-1:0]  entDest [`BR_RS_DEPTH];

    assign allocVec = (dispatchEn && !full) ? `BR_RS_DEPTH'(1) << tail : '0;

    // in-order issue, only the head entry is ever considered
    assign pop = ready[head];

    rsQueuePointers ptrs (
        .clk (clk),
        .rst (rst),
        .push(dispatchEn),
        .pop (pop),
        .head(head),
        .tail(tail),
        .full(full)
    );

    for (genvar i = 0; i < `BR_RS_DEPTH; i++) begin : gEntry
        rsEntry entry (
            .clk      (clk),
            .rst      (rst),
            .snoop    (snoop),
            .alloc    (allocVec[i]),
            .allocOp  (dispatchOp),
            .allocA   (dispatchA),
            .allocB   (dispatchB),
            .allocImm (dispatchImm),
            .allocTagA(dispatchTagA),
            .allocTagB(dispatchTagB),
            .allocDest(dispatchDest),
            .allocPc  (dispatchPc),
            .occupied (occupied[i]),
            .ready    (ready[i]),
            .opA      (entA[i]),
            .opB      (entB[i]),
            .imm      (entImm[i]),
            .op       (entOp[i]),
            .pc       (entPc[i]),
            .dest     (entDest[i])
        );
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            occupied <= '0;
            issueValid <= 1'b0;
        end else begin
            // head and tail only meet when empty or full, so the two updates never collide
            occupied <= (occupied | allocVec) & ~(pop ? `BR_RS_DEPTH'(1) << head : '0);
            issueValid <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            issueOp <= entOp[head];
            issueA <= entA[head];
            issueB <= entB[head];
            issueImm <= entImm[head];
            issuePc <= entPc[head];
            issueDest <= entDest[head];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/branchExec.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module branchExec (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  issueValid,
    input  branchPkg::brOpE       issueOp,
    input  logic [`BR_DATA_W-1:0] issueA,
    input  logic [`BR_DATA_W-1:0] issueB,
    input  logic [`BR_DATA_W-1:0] issueImm,
    input  logic [`BR_ADDR_W-1:0] issuePc,
    input  logic [`BR_TAG_W-1:0]  issueDest,
    output branchPkg::brResultT   result
);
    logic                  isEqual;
    logic                  lessSigned;
    logic                  lessUnsigned;
    logic                  taken;
    logic [`BR_ADDR_W-1:0] target;
    logic [`BR_ADDR_W-1:0] jumpBase;

    assign isEqual = issueA == issueB;
    assign lessSigned = $signed(issueA) < $signed(issueB);
    assign lessUnsigned = issueA < issueB;

    always_comb begin
        case (issueOp)
            branchPkg::BR_BEQ:  taken = isEqual;
            branchPkg::BR_BNE:  taken = !isEqual;
            branchPkg::BR_BLT:  taken = lessSigned;
            branchPkg::BR_BGE:  taken = !lessSigned;
            branchPkg::BR_BLTU: taken = lessUnsigned;
            branchPkg::BR_BGEU: taken = !lessUnsigned;
            branchPkg::BR_JAL:  taken = 1'b1;
            branchPkg::BR_JALR: taken = 1'b1;
            default:            taken = 1'b0;
        endcase
    end

    // JALR is register relative, everything else is PC relative
    assign jumpBase = (issueOp == branchPkg::BR_JALR) ? `BR_ADDR_W'(issueA) : issuePc;

    always_comb begin
        target = jumpBase + `BR_ADDR_W'(issueImm);
        if (issueOp == branchPkg::BR_JALR) begin
            target[0] = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else begin
            result.valid <= issueValid;
            result.taken <= taken;
            result.target <= target;
            result.link <= `BR_DATA_W'(issuePc + `BR_ADDR_W'(4));
            result.dest <= issueDest;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/branchTop.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module branchTop (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  dispatchEn,
    input  branchPkg::brOpE       dispatchOp,
    input  logic [`BR_DATA_W-1:0] dispatchA,
    input  logic [`BR_DATA_W-1:0] dispatchB,
    input  logic [`BR_DATA_W-1:0] dispatchImm,
    input  logic [`BR_TAG_W-1:0]  dispatchTagA,
    input  logic [`BR_TAG_W-1:0]  dispatchTagB,
    input  logic [`BR_TAG_W-1:0]  dispatchDest,
    input  logic [`BR_ADDR_W-1:0] dispatchPc,
    input  logic                  aluValid,
    input  logic [`BR_TAG_W-1:0]  aluTag,
    input  logic [`BR_DATA_W-1:0] aluData,
    input  logic                  lsValid,
    input  logic [`BR_TAG_W-1:0]  lsTag,
    input  logic [`BR_DATA_W-1:0] lsData,
    output logic                  rsFull,
    output logic                  resultValid,
    output logic                  resultTaken,
    output logic [`BR_ADDR_W-1:0] resultTarget,
    output logic [`BR_DATA_W-1:0] resultLink,
    output logic [`BR_TAG_W-1:0]  resultDest
);
    logic                  issueValid;
    branchPkg::brOpE       issueOp;
    logic [`BR_DATA_W-1:0] issueA;
    logic [`BR_DATA_W-1:0] issueB;
    logic [`BR_DATA_W-1:0] issueImm;
    logic [`BR_ADDR_W-1:0] issuePc;
    logic [`BR_TAG_W-1:0]  issueDest;
    branchPkg::brResultT   result;

    wakeupIf wakeup ();

    assign wakeup.aluValid = aluValid;
    assign wakeup.aluTag = aluTag;
    assign wakeup.aluData = aluData;
    assign wakeup.lsValid = lsValid;
    assign wakeup.lsTag = lsTag;
    assign wakeup.lsData = lsData;

    branchStation station (
        .clk(clk), .rst(rst), .snoop(wakeup.snoop),
        .dispatchEn(dispatchEn), .dispatchOp(dispatchOp),
        .dispatchA(dispatchA), .dispatchB(dispatchB), .dispatchImm(dispatchImm),
        .dispatchTagA(dispatchTagA), .dispatchTagB(dispatchTagB),
        .dispatchDest(dispatchDest), .dispatchPc(dispatchPc), .full(rsFull),
        .issueValid(issueValid), .issueOp(issueOp), .issueA(issueA), .issueB(issueB),
        .issueImm(issueImm), .issuePc(issuePc), .issueDest(issueDest)
    );

    branchExec exec (
        .clk(clk), .rst(rst), .issueValid(issueValid), .issueOp(issueOp),
        .issueA(issueA), .issueB(issueB), .issueImm(issueImm), .issuePc(issuePc),
        .issueDest(issueDest), .result(result)
    );

    assign resultValid = result.valid;
    assign resultTaken = result.taken;
    assign resultTarget = result.target;
    assign resultLink = result.link;
    assign resultDest = result.dest;

endmodule

`default_nettype wire

// ==== verification/branchUnit_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module branchUnitProperties (
    input logic clk,
    input logic rst,
    input logic dispatchEn,
    input logic full,
    input logic issueValid,
    input logic resultValid
);
    int failCount = 0;
    int inFlight;

    // accepted dispatches that have not come out as a result yet
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            inFlight <= 0;
        end else begin
            inFlight <= inFlight + int'(dispatchEn && !full) - int'(resultValid);
        end
    end

    // a strobe into a full station would be dropped by the pointers
    noDispatchWhenFull: assert property (@(posedge clk) disable iff (rst) !(dispatchEn && full))
        else begin
            $error("dispatch strobe while the station is full");
            failCount++;
        end

    resultNeedsIssue: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> $past(issueValid) && inFlight > 0)
        else begin
            $error("result valid without an accepted dispatch and an issue before it");
            failCount++;
        end

    // checked once reset has covered a whole cycle
    resultQuietInReset: assert property (@(posedge clk) rst && $past(rst) |-> !resultValid)
        else begin
            $error("result valid while reset is asserted");
            failCount++;
        end

endmodule

bind branchTop branchUnitProperties props (
    .clk        (clk),
    .rst        (rst),
    .dispatchEn (dispatchEn),
    .full       (rsFull),
    .issueValid (issueValid),
    .resultValid(resultValid)
);

`default_nettype wire

// ==== verification/branchChecker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module branchChecker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  recEn,
    input  branchPkg::brOpE       recOp,
    input  logic [`BR_DATA_W-1:0] recA,
    input  logic [`BR_DATA_W-1:0] recB,
    input  logic [`BR_DATA_W-1:0] recImm,
    input  logic [`BR_ADDR_W-1:0] recPc,
    input  logic [`BR_TAG_W-1:0]  recDest,
    input  logic                  resultValid,
    input  logic                  resultTaken,
    input  logic [`BR_ADDR_W-1:0] resultTarget,
    input  logic [`BR_DATA_W-1:0] resultLink,
    input  logic [`BR_TAG_W-1:0]  resultDest,
    output int                    errorCount,
    output int                    pendingCount
);
    branchPkg::brResultT expected[$];
    branchPkg::brResultT predicted;
    branchPkg::brResultT want;
    int errors = 0;

    function automatic logic branchTaken(input branchPkg::brOpE op,
                                         input logic [`BR_DATA_W-1:0] a,
                                         input logic [`BR_DATA_W-1:0] b);
        case (op)
            branchPkg::BR_BEQ:  return a == b;
            branchPkg::BR_BNE:  return a != b;
            branchPkg::BR_BLT:  return $signed(a) < $signed(b);
            branchPkg::BR_BGE:  return $signed(a) >= $signed(b);
            branchPkg::BR_BLTU: return a < b;
            branchPkg::BR_BGEU: return a >= b;
            branchPkg::BR_JAL:  return 1'b1;
            branchPkg::BR_JALR: return 1'b1;
            default:            return 1'b0;
        endcase
    endfunction

    // the dispatch inputs are steady at the rising edge, so the prediction is taken there
    always @(posedge clk) begin
        if (!rst && recEn) begin
            predicted.valid = 1'b1;
            predicted.taken = branchTaken(recOp, recA, recB);
            if (recOp == branchPkg::BR_JALR) begin
                predicted.target = (recA + recImm) & ~`BR_ADDR_W'(1);
            end else begin
                predicted.target = recPc + recImm;
            end
            predicted.link = recPc + `BR_ADDR_W'(4);
            predicted.dest = recDest;
            expected.push_back(predicted);
        end
    end

    always @(negedge clk) begin
        if (!rst && resultValid) begin
            if (expected.size() == 0) begin
                $display("[ERROR] %0t ns: result for dest %0d with no branch pending",
                         $time, resultDest);
                errors++;
            end else begin
                want = expected.pop_front();
                if (resultTaken !== want.taken || resultTarget !== want.target ||
                    resultLink !== want.link || resultDest !== want.dest) begin
                    $display("[ERROR] %0t ns: got %0b %h %h %0d, expected %0b %h %h %0d",
                             $time, resultTaken, resultTarget, resultLink, resultDest,
                             want.taken, want.target, want.link, want.dest);
                    errors++;
                end
            end
        end
    end

    assign errorCount = errors;
    assign pendingCount = expected.size();

endmodule

`default_nettype wire

// ==== verification/branchTb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "branch_macros.svh"

module branchTb;
    typedef struct packed {
        branchPkg::brOpE       op;
        logic [`BR_DATA_W-1:0] a;
        logic [`BR_DATA_W-1:0] b;
        logic [`BR_DATA_W-1:0] imm;
        logic [`BR_ADDR_W-1:0] pc;
        logic [`BR_TAG_W-1:0]  dest;
        logic [`BR_TAG_W-1:0]  tagA;
        logic [`BR_TAG_W-1:0]  tagB;
        bit                    useLs;
        int                    delay;
    } rowT;

    typedef struct packed {
        int                    due;
        logic [`BR_TAG_W-1:0]  tag;
        logic [`BR_DATA_W-1:0] data;
        bit                    useLs;
    } bcastT;

    logic clk = 1'b0;
    logic rst;
    logic dispatchEn;
    branchPkg::brOpE dispatchOp;
    logic [`BR_DATA_W-1:0] dispatchA;
    logic [`BR_DATA_W-1:0] dispatchB;
    logic [`BR_DATA_W-1:0] dispatchImm;
    logic [`BR_TAG_W-1:0] dispatchTagA;
    logic [`BR_TAG_W-1:0] dispatchTagB;
    logic [`BR_TAG_W-1:0] dispatchDest;
    logic [`BR_ADDR_W-1:0] dispatchPc;
    logic aluValid;
    logic [`BR_TAG_W-1:0] aluTag;
    logic [`BR_DATA_W-1:0] aluData;
    logic lsValid;
    logic [`BR_TAG_W-1:0] lsTag;
    logic [`BR_DATA_W-1:0] lsData;
    logic rsFull;
    logic resultValid;
    logic resultTaken;
    logic [`BR_ADDR_W-1:0] resultTarget;
    logic [`BR_DATA_W-1:0] resultLink;
    logic [`BR_TAG_W-1:0] resultDest;
    logic [`BR_DATA_W-1:0] trueA;
    logic [`BR_DATA_W-1:0] trueB;
    int checkErrors;
    int pendingCount;

    rowT rows[$];
    bcastT pending[$];
    logic [31:0] seed = 32'h2f82;
    int cycles = 0;
    int tbErrors = 0;
    int resultsSeen = 0;
    bit sawFull = 1'b0;
    int next;
    int cycle;
    int drain;

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= 40 * rows.size() + 200) begin
            $display("run timed out after %0d cycles, results never arrived", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    branchTop UUT (
        .clk(clk), .rst(rst), .dispatchEn(dispatchEn), .dispatchOp(dispatchOp),
        .dispatchA(dispatchA), .dispatchB(dispatchB), .dispatchImm(dispatchImm),
        .dispatchTagA(dispatchTagA), .dispatchTagB(dispatchTagB),
        .dispatchDest(dispatchDest), .dispatchPc(dispatchPc),
        .aluValid(aluValid), .aluTag(aluTag), .aluData(aluData),
        .lsValid(lsValid), .lsTag(lsTag), .lsData(lsData), .rsFull(rsFull),
        .resultValid(resultValid), .resultTaken(resultTaken), .resultTarget(resultTarget),
        .resultLink(resultLink), .resultDest(resultDest)
    );

    branchChecker resultCheck (
        .clk(clk), .rst(rst), .recEn(dispatchEn), .recOp(dispatchOp),
        .recA(trueA), .recB(trueB), .recImm(dispatchImm), .recPc(dispatchPc),
        .recDest(dispatchDest), .resultValid(resultValid), .resultTaken(resultTaken),
        .resultTarget(resultTarget), .resultLink(resultLink), .resultDest(resultDest),
        .errorCount(checkErrors), .pendingCount(pendingCount)
    );

    // xorshift32
    function automatic logic [31:0] nextRandom();
        seed = seed ^ (seed << 13);
        seed = seed ^ (seed >> 17);
        seed = seed ^ (seed << 5);
        return seed;
    endfunction

    task automatic addRow(input branchPkg::brOpE op, input logic [31:0] a,
                          input logic [31:0] b, input logic [31:0] imm,
                          input logic [3:0] tagA, input logic [3:0] tagB,
                          input bit useLs, input int delay);
        rows.push_back('{op, a, b, imm, `BR_ADDR_W'(32'h1000 + 4 * rows.size()),
                         `BR_TAG_W'(rows.size() + 1), tagA, tagB, useLs, delay});
    endtask

    task automatic buildTable();
        logic [31:0] v;
        v = nextRandom();
        addRow(branchPkg::BR_BEQ, v, v, 32'h40, 4'd0, 4'd0, 1'b0, 0);
        addRow(branchPkg::BR_BEQ, nextRandom(), nextRandom(), 32'hffff_fff0, 4'd0, 4'd0, 1'b0, 0);
        addRow(branchPkg::BR_BNE, nextRandom(), nextRandom(), 32'h7c, 4'd0, 4'd0, 1'b0, 0);
        addRow(branchPkg::BR_BNE, v, v, 32'h10, 4'd0, 4'd0, 1'b0, 0);
        // sign bits differ here, so signed and unsigned compares disagree
        addRow(branchPkg::BR_BLT, nextRandom() | 32'h8000_0000, nextRandom() >> 1,
               32'h20, 4'd0, 4'd0, 1'b0, 0);
        addRow(branchPkg::BR_BLTU, nextRandom() | 32'h8000_0000, nextRandom() >> 1,
               32'h24, 4'd0, 4'd0, 1'b0, 0);
        addRow(branchPkg::BR_BGEU, nextRandom() | 32'h8000_0000, nextRandom() >> 1,
               32'hffff_ff00, 4'd0, 4'd0, 1'b0, 0);
        addRow(branchPkg::BR_BLT, nextRandom(), nextRandom(), 32'h8, 4'd0, 4'd0, 1'b0, 0);
        addRow(branchPkg::BR_BGE, nextRandom(), nextRandom(), 32'h30, 4'd0, 4'd0, 1'b0, 0);
        addRow(branchPkg::BR_BGEU, nextRandom(), nextRandom(), 32'h44, 4'd0, 4'd0, 1'b0, 0);
        addRow(branchPkg::BR_JAL, nextRandom(), nextRandom(), 32'h800, 4'd0, 4'd0, 1'b0, 0);
        // an even base plus an odd offset, so bit 0 of the target has to be cleared
        addRow(branchPkg::BR_JALR, nextRandom() & 32'hffff_fffe, nextRandom(),
               32'h11, 4'd0, 4'd0, 1'b0, 0);
        // waiting operands, the first row wakes in the same cycle it reaches the head
        addRow(branchPkg::BR_BEQ, nextRandom(), nextRandom(), 32'h50, 4'd3, 4'd4, 1'b0, 1);
        addRow(branchPkg::BR_BEQ, v, v, 32'h54, 4'd7, 4'd0, 1'b1, 6);
        addRow(branchPkg::BR_BNE, v, v, 32'h58, 4'd0, 4'd8, 1'b0, 3);
        // four waiting rows fill the station and the fifth waits for room
        addRow(branchPkg::BR_BEQ, v, v, 32'h60, 4'd10, 4'd0, 1'b0, 12);
        addRow(branchPkg::BR_BNE, nextRandom(), nextRandom(), 32'h64, 4'd11, 4'd12, 1'b1, 14);
        addRow(branchPkg::BR_BGEU, nextRandom(), nextRandom(), 32'h68, 4'd0, 4'd13, 1'b1, 15);
        addRow(branchPkg::BR_JALR, nextRandom(), nextRandom(), 32'h6c, 4'd14, 4'd0, 1'b0, 16);
        addRow(branchPkg::BR_BNE, nextRandom(), nextRandom(), 32'h70, 4'd0, 4'd0, 1'b0, 0);
        // a ready branch queued behind a waiting head
        addRow(branchPkg::BR_BGE, nextRandom(), nextRandom(), 32'h74, 4'd9, 4'd0, 1'b0, 10);
        addRow(branchPkg::BR_BLT, nextRandom(), nextRandom(), 32'h78, 4'd0, 4'd0, 1'b0, 0);
    endtask

    task automatic initInputs();
        dispatchEn = 1'b0;
        dispatchOp = branchPkg::BR_NOP;
        dispatchA = '0;
        dispatchB = '0;
        dispatchImm = '0;
        dispatchTagA = '0;
        dispatchTagB = '0;
        dispatchDest = '0;
        dispatchPc = '0;
        aluValid = 1'b0;
        aluTag = '0;
        aluData = '0;
        lsValid = 1'b0;
        lsTag = '0;
        lsData = '0;
        trueA = '0;
        trueB = '0;
    endtask

    task automatic clearStrobes();
        dispatchEn = 1'b0;
        aluValid = 1'b0;
        lsValid = 1'b0;
    endtask

    // each bus carries one result per cycle, a late broadcast slips to the next cycle
    task automatic driveBroadcasts(input int now);
        bcastT keep[$];
        foreach (pending[i]) begin
            if (pending[i].due <= now && pending[i].useLs && !lsValid) begin
                lsValid = 1'b1;
                lsTag = pending[i].tag;
                lsData = pending[i].data;
            end else if (pending[i].due <= now && !pending[i].useLs && !aluValid) begin
                aluValid = 1'b1;
                aluTag = pending[i].tag;
                aluData = pending[i].data;
            end else begin
                keep.push_back(pending[i]);
            end
        end
        pending = keep;
    endtask

    task automatic dispatchRow(input rowT r, input int now);
        dispatchEn = 1'b1;
        dispatchOp = r.op;
        // a waiting operand gets stale data, so only the broadcast can make it right
        dispatchA = (r.tagA != '0) ? ~r.a : r.a;
        dispatchB = (r.tagB != '0) ? ~r.b : r.b;
        dispatchImm = r.imm;
        dispatchTagA = r.tagA;
        dispatchTagB = r.tagB;
        dispatchDest = r.dest;
        dispatchPc = r.pc;
        trueA = r.a;
        trueB = r.b;
        if (r.tagA != '0) begin
            pending.push_back('{now + r.delay, r.tagA, r.a, r.useLs});
        end
        if (r.tagB != '0) begin
            pending.push_back('{now + r.delay, r.tagB, r.b, (r.tagA != '0) ? !r.useLs : r.useLs});
        end
    endtask

    initial begin
        rst = 1'b1;
        initInputs();
        buildTable();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        repeat (3) begin
            @(negedge clk);
            if (rsFull || resultValid) begin
                $display("[ERROR] %0t ns: rsFull %0b resultValid %0b before any dispatch",
                         $time, rsFull, resultValid);
                tbErrors++;
            end
        end
        next = 0;
        cycle = 0;
        while (next < rows.size() || pending.size() != 0) begin
            @(negedge clk);
            clearStrobes();
            driveBroadcasts(cycle);
            if (resultValid) begin
                resultsSeen++;
            end
            if (rsFull) begin
                sawFull = 1'b1;
                // every slot holds a branch that has not produced its result yet
                if (next - resultsSeen < `BR_RS_DEPTH) begin
                    $display("[ERROR] %0t ns: rsFull high with only %0d branches in flight",
                             $time, next - resultsSeen);
                    tbErrors++;
                end
            end else if (next < rows.size()) begin
                dispatchRow(rows[next], cycle);
                next++;
            end
            cycle++;
        end
        @(negedge clk);
        clearStrobes();
        drain = 0;
        while (pendingCount != 0 && drain < 60) begin
            @(negedge clk);
            drain++;
        end
        repeat (4) @(negedge clk);
        if (!sawFull) begin
            $display("rsFull never went high while four branches were waiting");
            tbErrors++;
        end
        if (pendingCount != 0) begin
            $display("%0d dispatched branches never produced a result", pendingCount);
        end
        $display("errors: checker %0d, testbench %0d, assertions %0d, results missing %0d",
                 checkErrors, tbErrors, UUT.props.failCount, pendingCount);
        if (checkErrors + tbErrors + UUT.props.failCount + pendingCount == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
verilog/branchPkg.sv
verilog/wakeupIf.sv
verilog/rsEntry.sv
verilog/rsQueuePointers.sv
verilog/branchStation.sv
verilog/branchExec.sv
verilog/branchTop.sv
verification/branchUnit_properties.sv
verification/branchChecker.sv
verification/branchTb.sv

// ==== Makefile ====
TOOL       = verilator
TOP        = branchTb
FILELIST   = project.f
OBJ_DIR    = obj_dir
LINT_FLAGS = --lint-only --timing --assert --timescale 1ns/1ps -Wall
SIM_FLAGS  = --binary --timing --assert --timescale 1ns/1ps -Wno-fatal --Mdir $(OBJ_DIR)
RUN_FLAGS  = +verilator+error+limit+100
PASS_MSG   = ALL TESTS PASSED

.PHONY: lint sim clean

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# the run passes only when the pass message shows up in its output
sim:
	$(TOOL) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_FLAGS))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
